//--- vlog.f
+incdir+verif
src/udp_test_pkg.sv
src/gen_cfg_if.sv
src/cmd_decoder.sv
src/frame_sequencer.sv
src/payload_source.sv
src/udp_test_core.sv
verif/tb_udp_test_core.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    -f vlog.f \
    --top-module tb_udp_test_core \
    --Mdir obj_dir \
    -o tb_udp_test_core

./obj_dir/tb_udp_test_core | tee sim.log

grep -q 'All tests passed!' sim.log

//--- verif/tb_tasks.svh
// Drive, wait and compare tasks and the directed tests for the UDP test-traffic core testbench

// --------------------
// Checks

task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1);
endtask

task automatic compare_word(input string name, input word_t expected, input word_t actual);
    if (expected !== actual) begin
        stop_on_error($sformatf("error at %0t: %s expected %h, actual %h",
                                $time, name, expected, actual));
    end
endtask

task automatic compare_half(input string name, input half_t expected, input half_t actual);
    if (expected !== actual) begin
        stop_on_error($sformatf("error at %0t: %s expected %0d, actual %0d",
                                $time, name, expected, actual));
    end
endtask

task automatic compare_bit(input string name, input logic expected, input logic actual);
    if (expected !== actual) begin
        stop_on_error($sformatf("error at %0t: %s expected %b, actual %b",
                                $time, name, expected, actual));
    end
endtask

// --------------------
// Command words

// First character lands in the low byte
function automatic word_t text_word(input string s);
    word_t w;
    int    i;
    w = '0;
    for (i = 0; i < s.len() && i < 8; i++) begin
        w[8*i +: 8] = s[i];
    end
    return w;
endfunction

function automatic word_t arg32_cmd(input string kw, input logic [31:0] value);
    word_t w;
    w = text_word(kw);
    w[63:32] = {value[7:0], value[15:8], value[23:16], value[31:24]};  // MSB sent first
    return w;
endfunction

function automatic word_t arg16_cmd(input string kw, input logic [15:0] value);
    word_t w;
    w = text_word(kw);
    w[63:48] = {value[7:0], value[15:8]};
    return w;
endfunction

function automatic logic ready_bit();
    logic out;
    out        = ready_lfsr[0];
    ready_lfsr = ready_lfsr >> 1;
    if (out) begin
        ready_lfsr = ready_lfsr ^ READY_TAPS;
    end
    return out;
endfunction

task automatic send_cmd(input word_t word);
    cmd_data  = word;
    cmd_valid = 1'b1;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    repeat (2) @(posedge clk);   // Capture, then configuration update
    #1;
endtask

// --------------------
// Stream handling

// First word follows the trigger word by three edges
task automatic trigger_burst();
    cmd_data  = text_word("TRIGGER_");
    cmd_valid = 1'b1;
    @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    compare_bit("tx_valid after capture", 1'b0, tx_valid);
    @(posedge clk);
    #1;
    compare_bit("tx_valid after fire", 1'b0, tx_valid);
    @(posedge clk);
    #1;
    compare_bit("tx_valid three cycles after trigger", 1'b1, tx_valid);
endtask

task automatic take_packet();
    int    cycles;
    logic  done;
    logic  holding;
    word_t held;
    rx_words = {};
    cycles   = 0;
    done     = 1'b0;
    holding  = 1'b0;
    held     = '0;
    while (!done) begin
        if (holding) begin   // Word stalled on the previous cycle
            if (!tx_valid) begin
                stop_on_error("tx_valid dropped before the word was accepted");
            end
            compare_word("tx_data under back-pressure", held, tx_data);
        end
        if (random_ready) begin
            tx_ready = ready_bit();
        end else begin
            tx_ready = 1'b1;
        end
        holding = tx_valid && !tx_ready;
        held    = tx_data;
        if (tx_valid && tx_ready) begin
            rx_words.push_back(tx_data);
            done = tx_last;
        end
        @(posedge clk);
        #1;
        cycles++;
        if (cycles > PACKET_TIMEOUT) begin
            stop_on_error("timeout while waiting for a complete packet");
        end
    end
    if (!random_ready) begin
        tx_ready = 1'b0;     // Stack takes the packet
        @(posedge clk);
        #1;
    end
endtask

task automatic wait_valid();
    int cycles;
    cycles = 0;
    while (!tx_valid) begin
        @(posedge clk);
        #1;
        cycles++;
        if (cycles > PACKET_TIMEOUT) begin
            stop_on_error("timeout while waiting for tx_valid");
        end
    end
endtask

task automatic check_quiet(input int cycles);
    repeat (cycles) begin
        if (tx_valid) begin
            stop_on_error("tx_valid raised while the core should be idle");
        end
        @(posedge clk);
        #1;
    end
endtask

task automatic check_packet(input int index, input int pkt_count, input int words,
                            input int err_period, input int err_pos, input logic random_body);
    int   i;
    logic test_pkt;
    compare_half("packet length", half_t'(words), half_t'(rx_words.size()));
    compare_word("header word", {32'(index), 32'(pkt_count - 1)}, rx_words[1]);
    if (!(rx_words[0] < rx_words[words - 1])) begin
        stop_on_error("opening timestamp is not below the closing timestamp");
    end
    if (index > 0 && !(last_stamp < rx_words[0])) begin
        stop_on_error("opening timestamp did not advance from the previous packet");
    end
    last_stamp = rx_words[0];
    test_pkt   = 1'b0;
    if (err_period != 0) begin
        test_pkt = ((index + 1) % err_period) == 0;
    end
    for (i = 2; i < words - 1; i++) begin
        if (test_pkt && i == err_pos + 1) begin
            compare_word("injected test word", text_word("\n.TEST.\n"), rx_words[i]);
        end else if (random_body) begin
            body_words.push_back(rx_words[i]);
        end else begin
            compare_word("pattern body word", next_pattern, rx_words[i]);
            next_pattern++;
        end
    end
endtask

task automatic run_burst(input int pkt_count, input int words, input int err_period,
                         input int err_pos, input logic random_body);
    int p;
    next_pattern = '0;   // Pattern restarts with each burst
    body_words   = {};
    trigger_burst();
    for (p = 0; p < pkt_count; p++) begin
        take_packet();
        check_packet(p, pkt_count, words, err_period, err_pos, random_body);
    end
    check_quiet(QUIET_CYCLES);
endtask

// --------------------
// Directed tests

task automatic test_reset_and_length();
    compare_bit("tx_valid", 1'b0, tx_valid);
    compare_bit("led_armed", 1'b0, led_armed);
    compare_bit("led_random", 1'b0, led_random);
    compare_half("udp_length", 16'd8200, udp_length);
    send_cmd(arg16_cmd("LENGTH", 16'h0100));
    compare_half("udp_length", 16'd256, udp_length);
endtask

task automatic test_idle_disarmed();
    send_cmd(text_word("TRIGGER_"));
    compare_bit("led_armed", 1'b0, led_armed);
    check_quiet(QUIET_CYCLES);
endtask

task automatic test_counting_burst();
    send_cmd(arg32_cmd("PKT#", 32'd3));
    send_cmd(arg16_cmd("WORDS#", 16'd8));
    send_cmd(text_word("....INIT"));
    compare_bit("led_armed", 1'b1, led_armed);
    random_ready = 1'b0;
    run_burst(3, 8, 0, 0, 1'b0);
endtask

task automatic test_error_injection();
    send_cmd(arg32_cmd("ERR#", 32'd2));
    send_cmd(arg16_cmd("ERR_P#", 16'd3));
    random_ready = 1'b1;
    run_burst(3, 8, 2, 3, 1'b0);
endtask

task automatic test_random_mode();
    int   i;
    logic counting;
    logic all_equal;
    send_cmd(text_word("RANDOM_E"));
    compare_bit("led_random", 1'b1, led_random);
    run_burst(3, 8, 2, 3, 1'b1);
    if (body_words.size() < 2) begin
        stop_on_error("too few random body words were received");
    end
    counting  = 1'b1;
    all_equal = 1'b1;
    for (i = 0; i < body_words.size(); i++) begin
        if (body_words[i] != word_t'(i)) begin
            counting = 1'b0;
        end
        if (body_words[i] != body_words[0]) begin
            all_equal = 1'b0;
        end
    end
    if (counting) begin
        stop_on_error("random body words follow the counting pattern");
    end
    if (all_equal) begin
        stop_on_error("random body words are all equal");
    end
    send_cmd(text_word("RANDOM_D"));
    compare_bit("led_random", 1'b0, led_random);
endtask

task automatic test_fini_stop();
    random_ready = 1'b0;
    send_cmd(arg32_cmd("PKT#", 32'd1000));
    next_pattern = '0;
    body_words   = {};
    trigger_burst();
    take_packet();
    check_packet(0, 1000, 8, 2, 3, 1'b0);
    wait_valid();                     // Second packet stalls with tx_ready low
    send_cmd(text_word("....FINI"));
    compare_bit("led_armed", 1'b0, led_armed);
    take_packet();
    check_packet(1, 1000, 8, 2, 3, 1'b0);
    check_quiet(QUIET_CYCLES);
endtask

//--- verif/tb_udp_test_core.sv
// Testbench top for the UDP test-traffic core with clock, reset, DUT and directed test sequence
`timescale 1ns/1ps
`default_nettype none

module tb_udp_test_core
    import udp_test_pkg::*;
();

    localparam int          CLK_PERIOD     = 8;
    localparam int          PACKET_TIMEOUT = 500;   // Cycles allowed for one packet
    localparam int          QUIET_CYCLES   = 100;
    localparam logic [31:0] READY_SEED     = 32'd68559;
    localparam logic [31:0] READY_TAPS     = 32'h80200003;

    logic  clk;
    logic  rst;
    word_t cmd_data;
    logic  cmd_valid;
    word_t tx_data;
    logic  tx_valid;
    logic  tx_last;
    logic  tx_ready;
    half_t udp_length;
    logic  led_armed;
    logic  led_random;

    logic [31:0] ready_lfsr;     // Galois state behind tx_ready
    logic        random_ready;   // Toggle tx_ready instead of holding it high
    word_t       rx_words[$];    // Words of the packet just received
    word_t       body_words[$];  // Random body words of the current burst
    word_t       next_pattern;   // Expected counting body value
    word_t       last_stamp;     // Opening timestamp of the previous packet

    udp_test_core i_udp_test_core (
        .clk        (clk),
        .rst        (rst),
        .cmd_data   (cmd_data),
        .cmd_valid  (cmd_valid),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_last    (tx_last),
        .tx_ready   (tx_ready),
        .udp_length (udp_length),
        .led_armed  (led_armed),
        .led_random (led_random)
    );

    // --------------------
    // Clock

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    `include "tb_tasks.svh"

    // --------------------
    // Test sequence

    initial begin
        rst          = 1'b1;
        cmd_data     = '0;
        cmd_valid    = 1'b0;
        tx_ready     = 1'b0;
        ready_lfsr   = READY_SEED;
        random_ready = 1'b0;
        next_pattern = '0;
        last_stamp   = '0;

        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        test_reset_and_length();
        test_idle_disarmed();
        test_counting_burst();
        test_error_injection();
        test_random_mode();
        test_fini_stop();

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/udp_test_core.sv
// UDP test-traffic core top level with command input, word stream output and LEDs
`timescale 1ns/1ps
`default_nettype none

module udp_test_core
    import udp_test_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // Command words from the UDP stack
    input  word_t cmd_data,
    input  logic  cmd_valid,

    // Generated stream to the UDP stack
    output word_t tx_data,
    output logic  tx_valid,
    output logic  tx_last,
    input  logic  tx_ready,
    output half_t udp_length,

    output logic  led_armed,
    output logic  led_random
);

    gen_cfg_if cfg ();

    logic      load;
    word_sel_t sel;
    count_t    pkt_index;
    logic      burst_done;

    cmd_decoder i_cmd_decoder (
        .clk        (clk),
        .rst        (rst),
        .cmd_data   (cmd_data),
        .cmd_valid  (cmd_valid),
        .cfg        (cfg.decoder),
        .udp_length (udp_length)
    );

    frame_sequencer i_frame_sequencer (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg.sequencer),
        .tx_ready   (tx_ready),
        .tx_valid   (tx_valid),
        .tx_last    (tx_last),
        .load       (load),
        .sel        (sel),
        .pkt_index  (pkt_index),
        .burst_done (burst_done)
    );

    payload_source i_payload_source (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg.payload),
        .load       (load),
        .sel        (sel),
        .pkt_index  (pkt_index),
        .burst_done (burst_done),
        .tx_data    (tx_data)
    );

    assign led_armed  = cfg.armed;
    assign led_random = cfg.random_en;

endmodule

`default_nettype wire

//--- src/payload_source.sv
// Payload source with timestamp, LFSR and pattern generators behind the output data register
`timescale 1ns/1ps
`default_nettype none

module payload_source
    import udp_test_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    gen_cfg_if.payload cfg,
    input  logic       load,
    input  word_sel_t  sel,
    input  count_t     pkt_index,
    input  logic       burst_done,
    output word_t      tx_data
);

    word_t stamp;        // Free-running cycle count
    word_t lfsr;
    word_t pattern;      // Next incrementing body value
    logic  feedback;
    logic  pattern_step;

    // x^64 + x^63 + x^61 + x^60 + 1
    assign feedback = lfsr[63] ^ lfsr[62] ^ lfsr[60] ^ lfsr[59];

    assign pattern_step = load && (sel == SEL_BODY) && !cfg.random_en;

    // --------------------
    // Generators

    always_ff @(posedge clk) begin
        if (rst) begin
            stamp   <= '0;
            lfsr    <= LFSR_SEED;
            pattern <= '0;
        end else begin
            stamp <= stamp + word_t'(1);
            lfsr  <= {lfsr[WORD_W-2:0], feedback};  // Steps every cycle
            if (burst_done) begin
                pattern <= '0;
            end else if (pattern_step) begin
                pattern <= pattern + word_t'(1);
            end
        end
    end

    // --------------------
    // Output word

    always_ff @(posedge clk) begin
        if (load) begin
            case (sel)
                SEL_STAMP:  tx_data <= stamp;
                SEL_HEADER: tx_data <= {pkt_index, cfg.pkt_count - count_t'(1)};
                SEL_TEST:   tx_data <= TEST_WORD;
                default:    tx_data <= cfg.random_en ? lfsr : pattern;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/frame_sequencer.sv
// Burst and packet FSM that paces the word stream and selects each payload word
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer
    import udp_test_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    gen_cfg_if.sequencer cfg,
    input  logic         tx_ready,
    output logic         tx_valid,
    output logic         tx_last,
    output logic         load,
    output word_sel_t    sel,
    output count_t       pkt_index,
    output logic         burst_done
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FIRST,      // Opening timestamp on the bus
        ST_BODY,       // Header and body words
        ST_LAST,       // Closing timestamp on the bus
        ST_RDY_WAIT,
        ST_GAP
    } state_t;

    state_t           state;
    half_t            word_idx;  // Index of the word on the bus
    count_t           err_cnt;   // Packets until the next test packet
    logic [GAP_W-1:0] gap_cnt;
    half_t            last_idx;
    logic             start;
    logic             gap_done;
    logic             test_slot;
    logic             burst_end;

    assign start     = cfg.fire && cfg.armed;
    assign last_idx  = cfg.words_per_pkt - half_t'(2);  // Word before the closing stamp
    assign gap_done  = gap_cnt == GAP_W'(GAP_CYCLES - 1);
    assign burst_end = (pkt_index + count_t'(1) >= cfg.pkt_count) || !cfg.armed;

    // Test word follows word err_pos in every err_period-th packet
    assign test_slot = (cfg.err_period != '0) && (err_cnt == '0)
                       && (word_idx == cfg.err_pos);

    // --------------------
    // Word select

    always_comb begin
        load = 1'b0;
        sel  = SEL_STAMP;
        case (state)
            ST_IDLE:  load = start;
            ST_FIRST: begin
                load = tx_ready;
                sel  = SEL_HEADER;
            end
            ST_BODY: begin
                load = tx_ready;
                if (word_idx == last_idx) begin
                    sel = SEL_STAMP;
                end else if (test_slot) begin
                    sel = SEL_TEST;
                end else begin
                    sel = SEL_BODY;
                end
            end
            ST_GAP:   load = gap_done;
            default:  load = 1'b0;
        endcase
    end

    // --------------------
    // State and counters

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            tx_valid   <= 1'b0;
            tx_last    <= 1'b0;
            word_idx   <= '0;
            pkt_index  <= '0;
            err_cnt    <= '0;
            gap_cnt    <= '0;
            burst_done <= 1'b0;
        end else begin
            burst_done <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        tx_valid <= 1'b1;
                        err_cnt  <= cfg.err_period - count_t'(1);
                        state    <= ST_FIRST;
                    end
                end
                ST_FIRST: begin
                    if (tx_ready) begin
                        word_idx <= word_idx + half_t'(1);
                        state    <= ST_BODY;
                    end
                end
                ST_BODY: begin
                    if (tx_ready) begin
                        word_idx <= word_idx + half_t'(1);
                        if (word_idx == last_idx) begin
                            tx_last <= 1'b1;
                            state   <= ST_LAST;
                        end
                    end
                end
                ST_LAST: begin
                    // Closing word holds until accepted
                    if (tx_ready) begin
                        tx_valid <= 1'b0;
                        tx_last  <= 1'b0;
                        word_idx <= '0;
                        if (burst_end) begin
                            pkt_index  <= '0;
                            burst_done <= 1'b1;
                            state      <= ST_IDLE;
                        end else begin
                            pkt_index <= pkt_index + count_t'(1);
                            if (err_cnt == '0) begin
                                err_cnt <= cfg.err_period - count_t'(1);
                            end else begin
                                err_cnt <= err_cnt - count_t'(1);
                            end
                            state <= ST_RDY_WAIT;
                        end
                    end
                end
                ST_RDY_WAIT: begin
                    if (!tx_ready) begin   // Stack has taken the packet
                        gap_cnt <= '0;
                        state   <= ST_GAP;
                    end
                end
                ST_GAP: begin
                    if (gap_done) begin
                        tx_valid <= 1'b1;
                        state    <= ST_FIRST;
                    end else begin
                        gap_cnt <= gap_cnt + GAP_W'(1);
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/cmd_decoder.sv
// Command decoder that captures UDP command words into the generator configuration
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder
    import udp_test_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  word_t      cmd_data,
    input  logic       cmd_valid,
    gen_cfg_if.decoder cfg,
    output half_t      udp_length
);

    logic   valid_q;   // cmd_valid one cycle back
    word_t  cmd_q;     // Held command word
    count_t arg32;
    half_t  arg16;

    // --------------------
    // Capture and trigger

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q  <= 1'b0;
            cmd_q    <= '0;
            cfg.fire <= 1'b0;
        end else begin
            valid_q  <= cmd_valid;
            cfg.fire <= 1'b0;
            if (cmd_valid && !valid_q) begin
                cmd_q <= cmd_data;       // Rising edge only
            end else if (cmd_q == KW_TRIGGER) begin
                cfg.fire <= 1'b1;
                cmd_q    <= '0;          // Single pulse per trigger word
            end
        end
    end

    // Arguments arrive most significant byte first
    assign arg32 = {cmd_q[39:32], cmd_q[47:40], cmd_q[55:48], cmd_q[63:56]};
    assign arg16 = {cmd_q[55:48], cmd_q[63:56]};

    // --------------------
    // Configuration registers
    // A held word is applied every cycle until the next capture

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.armed         <= 1'b0;
            cfg.random_en     <= 1'b0;
            cfg.pkt_count     <= DEF_PKT_COUNT;
            cfg.err_period    <= DEF_ERR_PERIOD;
            cfg.err_pos       <= DEF_ERR_POS;
            cfg.words_per_pkt <= DEF_WORDS;
            udp_length        <= DEF_UDP_LENGTH;
        end else begin
            // Run control
            if (cmd_q[31:0] == KW_DOTS) begin
                case (cmd_q[63:32])
                    KW_INIT: cfg.armed <= 1'b1;
                    KW_FINI: cfg.armed <= 1'b0;
                    default: cfg.armed <= cfg.armed;
                endcase
            end

            if (cmd_q[55:0] == KW_RANDOM_PFX) begin
                case (cmd_q[63:56])
                    CH_E:    cfg.random_en <= 1'b1;
                    CH_D:    cfg.random_en <= 1'b0;
                    default: cfg.random_en <= cfg.random_en;
                endcase
            end

            // Numeric arguments
            if (cmd_q[31:0] == KW_PKT) begin
                cfg.pkt_count <= arg32;
            end
            if (cmd_q[31:0] == KW_ERR) begin
                cfg.err_period <= arg32;
            end
            if (cmd_q[47:0] == KW_ERR_P) begin
                cfg.err_pos <= arg16;
            end
            if (cmd_q[47:0] == KW_LENGTH) begin
                udp_length <= arg16;     // Passed on to the UDP stack
            end
            if (cmd_q[47:0] == KW_WORDS) begin
                cfg.words_per_pkt <= arg16;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/gen_cfg_if.sv
// Decoded generator configuration from the command decoder to the generator blocks
`timescale 1ns/1ps
`default_nettype none

interface gen_cfg_if
    import udp_test_pkg::*;
();

    logic   armed;          // INIT sets, FINI clears
    logic   fire;           // One cycle per trigger word
    logic   random_en;      // LFSR body words
    count_t pkt_count;      // Packets per burst
    count_t err_period;     // Zero disables test packets
    half_t  err_pos;
    half_t  words_per_pkt;

    modport decoder (
        output armed, fire, random_en, pkt_count, err_period, err_pos, words_per_pkt
    );

    modport sequencer (
        input armed, fire, pkt_count, err_period, err_pos, words_per_pkt
    );

    modport payload (
        input random_en, pkt_count
    );

endinterface

`default_nettype wire

//--- src/udp_test_pkg.sv
// UDP test-traffic core shared widths, command keywords, reset defaults and word select
`default_nettype none

package udp_test_pkg;

    // --------------------
    // Widths and types
    localparam int WORD_W = 64;

    typedef logic [WORD_W-1:0] word_t;   // Stream or command word
    typedef logic [31:0]       count_t;  // Packet count, error period
    typedef logic [15:0]       half_t;   // Word counts, positions, UDP length

    // --------------------
    // Command keywords
    // Byte images with the first character in the low byte
    localparam logic [63:0] KW_TRIGGER    = 64'h5F52454747495254; // TRIGGER_
    localparam logic [55:0] KW_RANDOM_PFX = 56'h5F4D4F444E4152;   // RANDOM_
    localparam logic [31:0] KW_DOTS       = 32'h2E2E2E2E;         // ....
    localparam logic [31:0] KW_INIT       = 32'h54494E49;         // INIT, upper half
    localparam logic [31:0] KW_FINI       = 32'h494E4946;         // FINI, upper half
    localparam logic [31:0] KW_PKT        = 32'h23544B50;         // PKT#
    localparam logic [31:0] KW_ERR        = 32'h23525245;         // ERR#
    localparam logic [47:0] KW_ERR_P      = 48'h23505F525245;     // ERR_P#
    localparam logic [47:0] KW_LENGTH     = 48'h4854474E454C;     // LENGTH
    localparam logic [47:0] KW_WORDS      = 48'h235344524F57;     // WORDS#

    localparam logic [7:0] CH_E = 8'h45;  // Enable suffix
    localparam logic [7:0] CH_D = 8'h44;  // Disable suffix

    // --------------------
    // Reset defaults
    // About 1 MB per trigger in 128 packets of 1024 words
    localparam count_t DEF_PKT_COUNT  = 32'd128;
    localparam count_t DEF_ERR_PERIOD = 32'd0;    // No test packets
    localparam half_t  DEF_ERR_POS    = 16'd128;
    localparam half_t  DEF_UDP_LENGTH = 16'd8200; // 8192 payload plus UDP header
    localparam half_t  DEF_WORDS      = 16'd1024;

    // Idle cycles between packets
    localparam int GAP_CYCLES = 20;
    localparam int GAP_W      = $clog2(GAP_CYCLES);

    // Generator constants
    localparam word_t LFSR_SEED = 64'h0123456789ABCDEF;
    localparam word_t TEST_WORD = 64'h0A2E545345542E0A; // "\n.TEST.\n"

    // Which word the payload source registers next
    typedef enum logic [1:0] {
        SEL_STAMP,
        SEL_HEADER,
        SEL_BODY,
        SEL_TEST
    } word_sel_t;

endpackage

`default_nettype wire
